/* src.f */
soc_pkg.sv
bus_arbiter.sv
sram_bank.sv
host_port.sv
dma_copy.sv
mini_soc.sv
vip_mini_soc.sv
fixture_mini_soc.sv

/* Makefile */
# Verilator build and run for the mini_soc testbench

VERILATOR ?= verilator
TOP       ?= fixture_mini_soc
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS JOBS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* fixture_mini_soc.sv */
/*
 * Testbench top for mini_soc. Generates clock and reset, connects the
 * DUT to the host VIP and ends the run on the VIP's error or finish flag.
 */

`timescale 1ns/100ps

module fixture_mini_soc;

  // Clock edges before the whole run counts as hung
  localparam int unsigned RunLimit = 20000;

  logic                      clk_i;
  logic                      rst_i;
  logic                      host_req_valid;
  soc_pkg::host_req_t        host_req;
  logic                      host_rsp_valid;
  logic [soc_pkg::DataW-1:0] host_rsp_data;
  logic                      dma_busy;
  logic                      dma_done;
  logic                      vip_error;
  logic                      vip_finished;

  ////////////////////
  // Clock and reset
  ////////////////////

  initial begin
    clk_i = 1'b0;
  end

  // 4 ns period
  always #2 clk_i = ~clk_i;

  initial begin
    rst_i = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
  end

  mini_soc uut (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .host_req_valid_i ( host_req_valid ),
    .host_req_i       ( host_req       ),
    .host_rsp_valid_o ( host_rsp_valid ),
    .host_rsp_data_o  ( host_rsp_data  ),
    .dma_busy_o       ( dma_busy       ),
    .dma_done_o       ( dma_done       )
  );

  vip_mini_soc vip (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .host_req_valid_o ( host_req_valid ),
    .host_req_o       ( host_req       ),
    .host_rsp_valid_i ( host_rsp_valid ),
    .host_rsp_data_i  ( host_rsp_data  ),
    .dma_busy_i       ( dma_busy       ),
    .dma_done_i       ( dma_done       ),
    .error_o          ( vip_error      ),
    .finished_o       ( vip_finished   )
  );

  ////////////////////
  // End of run
  ////////////////////

  initial begin : run_control
    int unsigned edges;
    edges = 0;
    while (vip_error !== 1'b1 && vip_finished !== 1'b1 && edges < RunLimit) begin
      @(posedge clk_i or posedge vip_error or posedge vip_finished);
      edges++;
    end
    if (vip_error === 1'b1 || vip_finished !== 1'b1) begin
      $display("TEST RESULT: FAIL");
      if (vip_error !== 1'b1) begin
        $display("Run limit reached before the test sequence finished");
      end
      $fatal(1, "Simulation stopped on a failure");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

/* vip_mini_soc.sv */
/*
 * Host-side VIP for mini_soc. Drives host strobes 1 ns after the clock,
 * keeps a reference copy of the SRAM and checks the DUT with concurrent
 * assertions. Raises error_o at the first failure and finished_o at the end.
 */

`timescale 1ns/100ps

module vip_mini_soc (
  input  logic                      clk_i,
  input  logic                      rst_i,
  output logic                      host_req_valid_o,
  output soc_pkg::host_req_t        host_req_o,
  input  logic                      host_rsp_valid_i,
  input  logic [soc_pkg::DataW-1:0] host_rsp_data_i,
  input  logic                      dma_busy_i,
  input  logic                      dma_done_i,
  output logic                      error_o,
  output logic                      finished_o
);

  localparam int unsigned WaitLimit = 2000;
  localparam logic [31:0] Seed      = 32'h33ef29bb;

  logic [soc_pkg::DataW-1:0] ref_mem [soc_pkg::MemWords];
  logic                      exp_valid_q;
  logic [soc_pkg::DataW-1:0] exp_data_q;
  logic                      stim_started;
  int unsigned               jobs_started;
  int unsigned               dones_seen_q;

  ////////////////////
  // Host driver
  ////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic raise_error(input string msg);
    $display("%s", msg);
    error_o = 1'b1;
  endtask

  // One strobe; memory writes update the reference model right away
  task automatic issue(input logic we, input logic [soc_pkg::HostAddrW-1:0] addr,
                       input logic [soc_pkg::DataW-1:0] data);
    stim_started     = 1'b1;
    host_req_valid_o = 1'b1;
    host_req_o.we    = we;
    host_req_o.addr  = addr;
    host_req_o.wdata = data;
    if (we && !addr[soc_pkg::HostAddrW-1]) begin
      ref_mem[addr[soc_pkg::MemAddrW-1:0]] = data;
    end
    next_cycle();
    host_req_valid_o = 1'b0;
  endtask

  task automatic mem_write(input logic [7:0] addr, input logic [31:0] data);
    issue(1'b1, {1'b0, addr}, data);
  endtask

  task automatic mem_read(input logic [7:0] addr);
    issue(1'b0, {1'b0, addr}, '0);
  endtask

  task automatic ctrl_write(input logic [7:0] addr, input logic [7:0] value);
    issue(1'b1, {1'b1, addr}, {24'h0, value});
  endtask

  task automatic wait_busy();
    int unsigned n;
    n = 0;
    while (!dma_busy_i && n <= WaitLimit) begin
      next_cycle();
      n++;
    end
    if (n > WaitLimit) begin
      raise_error("DMA never went busy after its length register was written");
    end
  endtask

  task automatic wait_done();
    int unsigned n;
    n = 0;
    while (!dma_done_i && n <= WaitLimit) begin
      next_cycle();
      n++;
    end
    if (n > WaitLimit) begin
      raise_error("DMA never pulsed done after its job");
    end
  endtask

  ////////////////////
  // Expected responses
  ////////////////////

  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_valid_q  <= 1'b0;
      exp_data_q   <= '0;
      dones_seen_q <= 0;
    end else begin
      exp_valid_q <= host_req_valid_o & ~host_req_o.we;
      // Control region reads as zero
      exp_data_q  <= host_req_o.addr[soc_pkg::HostAddrW-1] ? '0 :
                     ref_mem[host_req_o.addr[soc_pkg::MemAddrW-1:0]];
      if (dma_done_i) begin
        dones_seen_q <= dones_seen_q + 1;
      end
    end
  end

  a_quiet_after_reset : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !stim_started |-> !(host_rsp_valid_i || dma_busy_i || dma_done_i)
  ) else raise_error($sformatf(
    "FAILED host_rsp_valid_o/dma_busy_o/dma_done_o after reset: got %h/%h/%h, expected 0/0/0",
    $sampled(host_rsp_valid_i), $sampled(dma_busy_i), $sampled(dma_done_i)));

  a_rsp_latency : assert property (
    @(posedge clk_i) disable iff (rst_i)
    host_rsp_valid_i == exp_valid_q
  ) else raise_error($sformatf("FAILED host_rsp_valid_o: got %h, expected %h",
    $sampled(host_rsp_valid_i), $sampled(exp_valid_q)));

  a_rsp_data : assert property (
    @(posedge clk_i) disable iff (rst_i)
    host_rsp_valid_i |-> host_rsp_data_i == exp_data_q
  ) else raise_error($sformatf("FAILED host_rsp_data_o: got %h, expected %h",
    $sampled(host_rsp_data_i), $sampled(exp_data_q)));

  // One done per accepted job, so an ignored restart adds none
  a_done_per_job : assert property (
    @(posedge clk_i) disable iff (rst_i)
    dma_done_i |-> dones_seen_q < jobs_started
  ) else raise_error("DMA pulsed done more often than jobs were started");

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : run_sequence
    int unsigned i;
    int unsigned n;
    logic [7:0]  src;
    logic [7:0]  dst;
    logic [7:0]  len;
    logic [7:0]  addr;
    host_req_valid_o = 1'b0;
    host_req_o       = '0;
    error_o          = 1'b0;
    finished_o       = 1'b0;
    stim_started     = 1'b0;
    jobs_started     = 0;
    void'($urandom(Seed));

    n = 0;
    while ((rst_i !== 1'b0) && n <= WaitLimit) begin
      next_cycle();
      n++;
    end
    if (n > WaitLimit) begin
      raise_error("Reset was never released");
    end
    repeat (4) next_cycle();

    // Fill every word, then mixed random traffic
    for (i = 0; i < soc_pkg::MemWords; i++) begin
      mem_write(i[7:0], $urandom());
    end
    repeat (200) begin
      addr = 8'($urandom());
      if ($urandom_range(0, 1) == 1) begin
        mem_write(addr, $urandom());
      end else begin
        mem_read(addr);
      end
    end
    issue(1'b0, {1'b1, soc_pkg::RegSrc}, '0);
    issue(1'b0, {1'b1, soc_pkg::RegLen}, '0);

    // Copy job from 0x00-0x3f into 0x40-0x7f
    src = 8'($urandom_range(0, 31));
    dst = 8'h40 + 8'($urandom_range(0, 31));
    len = 8'($urandom_range(8, 32));
    ctrl_write(soc_pkg::RegSrc, src);
    ctrl_write(soc_pkg::RegDst, dst);
    jobs_started++;
    ctrl_write(soc_pkg::RegLen, len);
    wait_busy();

    // Restart while busy, aimed at 0xe0
    ctrl_write(soc_pkg::RegSrc, 8'h00);
    ctrl_write(soc_pkg::RegDst, 8'he0);
    ctrl_write(soc_pkg::RegLen, 8'h08);

    // Host traffic in 0x80-0xdf for as long as the copy runs
    n = 0;
    while (dma_busy_i && n <= WaitLimit) begin
      addr = 8'h80 + 8'($urandom_range(0, 95));
      case ($urandom_range(0, 2))
        0:       mem_write(addr, $urandom());
        1:       mem_read(addr);
        default: next_cycle();
      endcase
      n++;
    end
    if (n > WaitLimit) begin
      raise_error("DMA stayed busy far longer than its job needs");
    end
    wait_done();

    for (i = 0; i < len; i++) begin
      ref_mem[8'(dst + i)] = ref_mem[8'(src + i)];
    end
    for (i = 0; i < len; i++) begin
      mem_read(8'(dst + i));
      mem_read(8'(src + i));
    end
    for (i = 0; i < 8; i++) begin
      mem_read(8'he0 + i[7:0]);
    end
    repeat (8) next_cycle();
    finished_o = 1'b1;
  end

endmodule

/* mini_soc.sv */
/*
 * Top level of the memory subsystem. The host port and the DMA engine
 * share one SRAM bank through a fixed-priority arbiter.
 */

`timescale 1ns/100ps

module mini_soc (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      host_req_valid_i,
  input  soc_pkg::host_req_t        host_req_i,
  output logic                      host_rsp_valid_o,
  output logic [soc_pkg::DataW-1:0] host_rsp_data_o,
  output logic                      dma_busy_o,
  output logic                      dma_done_o
);

  logic                      host_bus_valid;
  soc_pkg::bus_req_t         host_bus_req;
  logic                      host_rdata_valid;
  logic                      dma_bus_valid;
  soc_pkg::bus_req_t         dma_bus_req;
  logic                      dma_gnt;
  logic                      dma_rdata_valid;
  logic                      dma_start;
  soc_pkg::dma_cfg_t         dma_cfg;
  logic                      mem_valid;
  soc_pkg::bus_req_t         mem_req;
  logic [soc_pkg::DataW-1:0] mem_rdata;
  logic [soc_pkg::DataW-1:0] bus_rdata;

  ////////////////////
  // Masters
  ////////////////////

  host_port i_host_port (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .host_req_valid_i ( host_req_valid_i ),
    .host_req_i       ( host_req_i       ),
    .host_rsp_valid_o ( host_rsp_valid_o ),
    .host_rsp_data_o  ( host_rsp_data_o  ),
    .bus_req_valid_o  ( host_bus_valid   ),
    .bus_req_o        ( host_bus_req     ),
    .rdata_valid_i    ( host_rdata_valid ),
    .rdata_i          ( bus_rdata        ),
    .dma_start_o      ( dma_start        ),
    .dma_cfg_o        ( dma_cfg          )
  );

  dma_copy i_dma_copy (
    .clk_i         ( clk_i           ),
    .rst_i         ( rst_i           ),
    .start_i       ( dma_start       ),
    .cfg_i         ( dma_cfg         ),
    .req_valid_o   ( dma_bus_valid   ),
    .req_o         ( dma_bus_req     ),
    .gnt_i         ( dma_gnt         ),
    .rdata_valid_i ( dma_rdata_valid ),
    .rdata_i       ( bus_rdata       ),
    .busy_o        ( dma_busy_o      ),
    .done_o        ( dma_done_o      )
  );

  ////////////////////
  // Shared SRAM
  ////////////////////

  bus_arbiter i_bus_arbiter (
    .clk_i              ( clk_i            ),
    .rst_i              ( rst_i            ),
    .host_req_valid_i   ( host_bus_valid   ),
    .host_req_i         ( host_bus_req     ),
    .dma_req_valid_i    ( dma_bus_valid    ),
    .dma_req_i          ( dma_bus_req      ),
    .dma_gnt_o          ( dma_gnt          ),
    .mem_req_valid_o    ( mem_valid        ),
    .mem_req_o          ( mem_req          ),
    .mem_rdata_i        ( mem_rdata        ),
    .host_rdata_valid_o ( host_rdata_valid ),
    .dma_rdata_valid_o  ( dma_rdata_valid  ),
    .rdata_o            ( bus_rdata        )
  );

  sram_bank i_sram_bank (
    .clk_i       ( clk_i     ),
    .req_valid_i ( mem_valid ),
    .req_i       ( mem_req   ),
    .rdata_o     ( mem_rdata )
  );

endmodule

/* dma_copy.sv */
/*
 * Block-copy engine. Each word is one read and one write on the shared
 * SRAM port; the write is issued in the cycle the read data returns and
 * retried from a holding register if the host takes that cycle.
 */

`timescale 1ns/100ps

module dma_copy (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      start_i,
  input  soc_pkg::dma_cfg_t         cfg_i,
  output logic                      req_valid_o,
  output soc_pkg::bus_req_t         req_o,
  input  logic                      gnt_i,
  input  logic                      rdata_valid_i,
  input  logic [soc_pkg::DataW-1:0] rdata_i,
  output logic                      busy_o,
  output logic                      done_o
);

  typedef enum logic [1:0] {
    StIdle,
    StRead,
    StWaitData,
    StWrite
  } state_e;

  state_e                       state_q;
  logic                         done_q;
  logic [soc_pkg::MemAddrW-1:0] src_q;
  logic [soc_pkg::MemAddrW-1:0] dst_q;
  logic [soc_pkg::MemAddrW-1:0] left_q;
  logic [soc_pkg::DataW-1:0]    data_q;
  logic                         wr_fire;
  logic                         last_word;

  ////////////////////
  // Bus request
  ////////////////////

  always_comb begin
    req_valid_o = 1'b0;
    req_o       = '0;
    case (state_q)
      StRead: begin
        req_valid_o = 1'b1;
        req_o.addr  = src_q;
      end
      // Write straight from the returning read data
      StWaitData: begin
        req_valid_o = rdata_valid_i;
        req_o.we    = 1'b1;
        req_o.addr  = dst_q;
        req_o.wdata = rdata_i;
      end
      StWrite: begin
        req_valid_o = 1'b1;
        req_o.we    = 1'b1;
        req_o.addr  = dst_q;
        req_o.wdata = data_q;
      end
      default: ;
    endcase
  end

  assign wr_fire   = gnt_i & req_o.we;
  assign last_word = (left_q == soc_pkg::MemAddrW'(1));

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= StIdle;
      done_q  <= 1'b0;
    end else begin
      done_q <= wr_fire & last_word;
      case (state_q)
        // Zero length jobs are dropped
        StIdle:     if (start_i && cfg_i.len != '0) state_q <= StRead;
        StRead:     if (gnt_i) state_q <= StWaitData;
        StWaitData: begin
          if (wr_fire) begin
            state_q <= last_word ? StIdle : StRead;
          end else if (rdata_valid_i) begin
            state_q <= StWrite;
          end
        end
        StWrite:    if (wr_fire) state_q <= last_word ? StIdle : StRead;
        default:    state_q <= StIdle;
      endcase
    end
  end

  // Counters and holding register
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle && start_i) begin
      src_q  <= cfg_i.src;
      dst_q  <= cfg_i.dst;
      left_q <= cfg_i.len;
    end
    if (state_q == StWaitData && rdata_valid_i) begin
      data_q <= rdata_i;
    end
    if (wr_fire) begin
      src_q  <= src_q + 1'b1;
      dst_q  <= dst_q + 1'b1;
      left_q <= left_q - 1'b1;
    end
  end

  assign busy_o = (state_q != StIdle);
  assign done_o = done_q;

  // Read data must come back in the cycle after a granted read
  a_read_returns : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (req_valid_o && gnt_i && !req_o.we) |=> rdata_valid_i
  );

endmodule

/* host_port.sv */
/*
 * Host-side port. Memory accesses go to the arbiter; writes to the
 * control region load the DMA registers and a length write starts a job.
 * Reads are answered exactly one cycle after the request strobe.
 */

`timescale 1ns/100ps

module host_port (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      host_req_valid_i,
  input  soc_pkg::host_req_t        host_req_i,
  output logic                      host_rsp_valid_o,
  output logic [soc_pkg::DataW-1:0] host_rsp_data_o,
  output logic                      bus_req_valid_o,
  output soc_pkg::bus_req_t         bus_req_o,
  input  logic                      rdata_valid_i,
  input  logic [soc_pkg::DataW-1:0] rdata_i,
  output logic                      dma_start_o,
  output soc_pkg::dma_cfg_t         dma_cfg_o
);

  logic                         ctrl_sel;
  logic                         ctrl_rd_q;
  logic                         start_q;
  logic [soc_pkg::MemAddrW-1:0] src_q;
  logic [soc_pkg::MemAddrW-1:0] dst_q;
  logic [soc_pkg::MemAddrW-1:0] len_q;

  assign ctrl_sel = host_req_i.addr[soc_pkg::HostAddrW-1];

  // Memory region goes straight to the arbiter
  assign bus_req_valid_o = host_req_valid_i & ~ctrl_sel;
  assign bus_req_o.we    = host_req_i.we;
  assign bus_req_o.addr  = host_req_i.addr[soc_pkg::MemAddrW-1:0];
  assign bus_req_o.wdata = host_req_i.wdata;

  ////////////////////
  // Control registers
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ctrl_rd_q <= 1'b0;
      start_q   <= 1'b0;
      src_q     <= '0;
      dst_q     <= '0;
      len_q     <= '0;
    end else begin
      ctrl_rd_q <= host_req_valid_i & ctrl_sel & ~host_req_i.we;
      start_q   <= 1'b0;
      if (host_req_valid_i && ctrl_sel && host_req_i.we) begin
        case (host_req_i.addr[soc_pkg::MemAddrW-1:0])
          soc_pkg::RegSrc: src_q <= host_req_i.wdata[soc_pkg::MemAddrW-1:0];
          soc_pkg::RegDst: dst_q <= host_req_i.wdata[soc_pkg::MemAddrW-1:0];
          soc_pkg::RegLen: begin
            len_q   <= host_req_i.wdata[soc_pkg::MemAddrW-1:0];
            start_q <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  assign dma_start_o   = start_q;
  assign dma_cfg_o.src = src_q;
  assign dma_cfg_o.dst = dst_q;
  assign dma_cfg_o.len = len_q;

  // Control reads answer zero
  assign host_rsp_valid_o = rdata_valid_i | ctrl_rd_q;
  assign host_rsp_data_o  = ctrl_rd_q ? '0 : rdata_i;

endmodule

/* sram_bank.sv */
/*
 * Single-port SRAM bank. Writes land on the clock edge, reads return
 * registered data in the following cycle.
 */

`timescale 1ns/100ps

module sram_bank (
  input  logic                      clk_i,
  input  logic                      req_valid_i,
  input  soc_pkg::bus_req_t         req_i,
  output logic [soc_pkg::DataW-1:0] rdata_o
);

  logic [soc_pkg::DataW-1:0] mem_q [soc_pkg::MemWords];
  logic [soc_pkg::DataW-1:0] rdata_q;

  // Storage array
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      if (req_i.we) begin
        mem_q[req_i.addr] <= req_i.wdata;
      end else begin
        rdata_q <= mem_q[req_i.addr];
      end
    end
  end

  // Read data holds until the next read
  assign rdata_o = rdata_q;

  a_req_known : assert property (
    @(posedge clk_i)
    req_valid_i |-> !$isunknown({req_i.we, req_i.addr})
  );

  // Write data must be defined, read data may be anything
  a_wdata_known : assert property (
    @(posedge clk_i)
    (req_valid_i && req_i.we) |-> !$isunknown(req_i.wdata)
  );

endmodule

/* bus_arbiter.sv */
/*
 * Fixed-priority arbiter in front of the single SRAM port. The host
 * always wins, the DMA is granted only in idle host cycles. Read data
 * comes back one cycle later and is flagged for the master that issued it.
 */

`timescale 1ns/100ps

module bus_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     host_req_valid_i,
  input  soc_pkg::bus_req_t        host_req_i,
  input  logic                     dma_req_valid_i,
  input  soc_pkg::bus_req_t        dma_req_i,
  output logic                     dma_gnt_o,
  output logic                     mem_req_valid_o,
  output soc_pkg::bus_req_t        mem_req_o,
  input  logic [soc_pkg::DataW-1:0] mem_rdata_i,
  output logic                     host_rdata_valid_o,
  output logic                     dma_rdata_valid_o,
  output logic [soc_pkg::DataW-1:0] rdata_o
);

  logic host_rd_q;
  logic dma_rd_q;

  ////////////////////
  // Request select
  ////////////////////

  assign dma_gnt_o       = dma_req_valid_i & ~host_req_valid_i;
  assign mem_req_valid_o = host_req_valid_i | dma_req_valid_i;
  assign mem_req_o       = host_req_valid_i ? host_req_i : dma_req_i;

  // Remember who owns the read that is in flight
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      host_rd_q <= 1'b0;
      dma_rd_q  <= 1'b0;
    end else begin
      host_rd_q <= host_req_valid_i & ~host_req_i.we;
      dma_rd_q  <= dma_gnt_o & ~dma_req_i.we;
    end
  end

  ////////////////////
  // Read return
  ////////////////////

  assign host_rdata_valid_o = host_rd_q;
  assign dma_rdata_valid_o  = dma_rd_q;
  // SRAM data is already registered, both masters see the same word
  assign rdata_o            = mem_rdata_i;

  // A DMA request that loses stays unchanged until it is granted
  a_dma_hold : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (dma_req_valid_i && !dma_gnt_o) |=> (dma_req_valid_i && $stable(dma_req_i))
  );

endmodule

/* soc_pkg.sv */
/*
 * Shared widths, address map and bus structs for the mini_soc memory
 * subsystem. Every design file refers to these by scoped names.
 */

package soc_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned DataW     = 32;
  localparam int unsigned MemAddrW  = 8;
  localparam int unsigned MemWords  = 1 << MemAddrW;
  // Top bit of the host address selects the control region
  localparam int unsigned HostAddrW = MemAddrW + 1;

  ////////////////////
  // Control registers
  ////////////////////

  localparam logic [MemAddrW-1:0] RegSrc = 8'h00;
  localparam logic [MemAddrW-1:0] RegDst = 8'h01;
  // Writing the length also starts the copy
  localparam logic [MemAddrW-1:0] RegLen = 8'h02;

  typedef struct packed {
    logic                 we;
    logic [HostAddrW-1:0] addr;
    logic [DataW-1:0]     wdata;
  } host_req_t;

  // One SRAM access, shared by both masters and the arbiter
  typedef struct packed {
    logic                we;
    logic [MemAddrW-1:0] addr;
    logic [DataW-1:0]    wdata;
  } bus_req_t;

  // One DMA job; len of zero copies nothing
  typedef struct packed {
    logic [MemAddrW-1:0] src;
    logic [MemAddrW-1:0] dst;
    logic [MemAddrW-1:0] len;
  } dma_cfg_t;

endpackage
